/* u2_rx_settings.svh */
`ifndef U2_RX_SETTINGS_SVH
`define U2_RX_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus register map

// Time registers, high word then low word (low word commits)
`define U2_SR_TIME64      10

// Front end: I offset, Q offset, swap
`define U2_SR_RX_FRONT    24

// RX control: run, samples per packet, decimation, clear
`define U2_SR_RX_CTRL     32

////////////////////////////////////////////////////////////////////////////
// Data path sizes

`define U2_ADC_WIDTH      14
`define U2_SET_DATA_WIDTH 32

// FIFO depths as address bits
`define U2_SAMPLE_FIFO_AW 3
`define U2_OUT_FIFO_AW    4

`endif

/* u2_rx_pkg.sv */
package u2_rx_pkg;

   // Free running VITA time in clock ticks
   typedef logic [63:0] vita_time_t;

   // Settings bus address
   typedef logic [7:0] set_addr_t;

   // One complex sample, I in the upper half
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } sample_t;

   // Sample FIFO payload
   typedef struct packed {
      vita_time_t ts;   // Time at capture
      sample_t    smp;
   } stamped_sample_t;

   // Output FIFO payload, flag bit 0 is SOP and bit 1 is EOP
   typedef struct packed {
      logic [3:0]  flags;
      logic [31:0] data;
   } line36_t;

endpackage

/* rx_settings_regs.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module rx_settings_regs (
   input  logic                          dsp_clk,
   input  logic                          por_rst,
   input  logic                          set_stb_i,
   input  u2_rx_pkg::set_addr_t          set_addr_i,
   input  logic [`U2_SET_DATA_WIDTH-1:0] set_data_i,
   output logic [15:0]                   offset_i_o,
   output logic [15:0]                   offset_q_o,
   output logic                          swap_iq_o,
   output logic                          run_o,
   output logic [7:0]                    spp_o,
   output logic [7:0]                    decim_o,
   output logic                          clear_o
);

   import u2_rx_pkg::*;

   localparam set_addr_t ADDR_OFS_I = set_addr_t'(`U2_SR_RX_FRONT + 0);
   localparam set_addr_t ADDR_OFS_Q = set_addr_t'(`U2_SR_RX_FRONT + 1);
   localparam set_addr_t ADDR_SWAP  = set_addr_t'(`U2_SR_RX_FRONT + 2);
   localparam set_addr_t ADDR_RUN   = set_addr_t'(`U2_SR_RX_CTRL + 0);
   localparam set_addr_t ADDR_SPP   = set_addr_t'(`U2_SR_RX_CTRL + 1);
   localparam set_addr_t ADDR_DECIM = set_addr_t'(`U2_SR_RX_CTRL + 2);
   localparam set_addr_t ADDR_CLEAR = set_addr_t'(`U2_SR_RX_CTRL + 3);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         offset_i_o <= 16'd0;
         offset_q_o <= 16'd0;
         swap_iq_o  <= 1'b0;
         run_o      <= 1'b0;
         spp_o      <= 8'd1;   // At least one sample per packet
         decim_o    <= 8'd0;
         clear_o    <= 1'b0;
      end else begin
         clear_o <= 1'b0;   // Pulse only
         if (set_stb_i) begin
            case (set_addr_i)
               ADDR_OFS_I: offset_i_o <= set_data_i[15:0];
               ADDR_OFS_Q: offset_q_o <= set_data_i[15:0];
               ADDR_SWAP:  swap_iq_o  <= set_data_i[0];
               ADDR_RUN:   run_o      <= set_data_i[0];
               ADDR_SPP: begin
                  // Zero would mean an empty packet
                  if (set_data_i[7:0] == 8'd0)
                     spp_o <= 8'd1;
                  else
                     spp_o <= set_data_i[7:0];
               end
               ADDR_DECIM: decim_o    <= set_data_i[7:0];
               ADDR_CLEAR: clear_o    <= 1'b1;   // Data ignored
               default: ;
            endcase
         end
      end
   end

endmodule

/* vita_time_counter.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module vita_time_counter (
   input  logic                          dsp_clk,
   input  logic                          por_rst,
   input  logic                          set_stb_i,
   input  u2_rx_pkg::set_addr_t          set_addr_i,
   input  logic [`U2_SET_DATA_WIDTH-1:0] set_data_i,
   output u2_rx_pkg::vita_time_t         vita_time_o
);

   import u2_rx_pkg::*;

   localparam set_addr_t ADDR_HI = set_addr_t'(`U2_SR_TIME64 + 0);
   localparam set_addr_t ADDR_LO = set_addr_t'(`U2_SR_TIME64 + 1);

   logic [31:0] time_hi_q;   // Pending high word

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_q   <= 32'd0;
         vita_time_o <= '0;
      end else begin
         if (set_stb_i && (set_addr_i == ADDR_HI))
            time_hi_q <= set_data_i;

         // Low word write commits the whole 64 bit value
         if (set_stb_i && (set_addr_i == ADDR_LO))
            vita_time_o <= {time_hi_q, set_data_i};
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

endmodule

/* rx_frontend.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module rx_frontend (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic [`U2_ADC_WIDTH-1:0]   adc_i_i,
   input  logic [`U2_ADC_WIDTH-1:0]   adc_q_i,
   input  logic [15:0]                offset_i_i,
   input  logic [15:0]                offset_q_i,
   input  logic                       swap_iq_i,
   input  logic                       run_i,
   input  logic [7:0]                 decim_i,
   input  logic                       clear_i,
   input  u2_rx_pkg::vita_time_t      vita_time_i,
   input  logic                       smp_ready_i,
   output u2_rx_pkg::stamped_sample_t smp_o,
   output logic                       smp_valid_o,
   output logic                       overrun_o
);

   import u2_rx_pkg::*;

   logic                     run_d;
   logic [7:0]               decim_cnt;   // Cycles since last capture
   logic                     strobe;
   logic                     smp_pend;
   logic                     smp_lost;
   logic [`U2_ADC_WIDTH-1:0] chan_i;
   logic [`U2_ADC_WIDTH-1:0] chan_q;
   sample_t                  corr;

   // Fire at once on run rising, then every decim+1 cycles
   assign strobe   = run_i && !overrun_o && (!run_d || (decim_cnt >= decim_i));
   assign smp_lost = smp_pend && !smp_ready_i;

   always_comb begin
      chan_i = swap_iq_i ? adc_q_i : adc_i_i;
      chan_q = swap_iq_i ? adc_i_i : adc_q_i;
      // Sign extend, then remove DC, wraps mod 2^16
      corr.i = {{(16-`U2_ADC_WIDTH){chan_i[`U2_ADC_WIDTH-1]}}, chan_i} - offset_i_i;
      corr.q = {{(16-`U2_ADC_WIDTH){chan_q[`U2_ADC_WIDTH-1]}}, chan_q} - offset_q_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_d     <= 1'b0;
         decim_cnt <= 8'd0;
         smp_pend  <= 1'b0;
         overrun_o <= 1'b0;
      end else begin
         run_d <= run_i;
         if (!run_i || strobe)
            decim_cnt <= 8'd0;
         else
            decim_cnt <= decim_cnt + 8'd1;
         smp_pend <= strobe && !clear_i && !smp_lost;
         if (clear_i)
            overrun_o <= 1'b0;
         else if (smp_lost)
            overrun_o <= 1'b1;   // Sticky until clear
      end
   end

   // Capture stage, stamp is the time before this edge's increment
   always_ff @(posedge dsp_clk) begin
      if (strobe) begin
         smp_o.ts  <= vita_time_i;
         smp_o.smp <= corr;
      end
   end

   assign smp_valid_o = smp_pend;

endmodule

/* stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  AW        = 3
) (
   input  logic     dsp_clk,
   input  logic     por_rst,
   input  logic     clear_i,
   input  payload_t in_data_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output payload_t out_data_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);

   localparam int DEPTH = 1 << AW;

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;   // Occupancy, one extra bit for full
   logic          push;
   logic          pop;

   assign in_ready_o  = (count != (AW+1)'(DEPTH));
   assign out_valid_o = (count != '0);
   assign out_data_o  = mem[rd_ptr];   // Head stays put until popped

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (AW+1)'(push) - (AW+1)'(pop);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Storage

   always_ff @(posedge dsp_clk) begin
      if (push)
         mem[wr_ptr] <= in_data_i;
   end

endmodule

/* vita_rx_framer.sv */
`timescale 1ns/1ps

module vita_rx_framer (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       clear_i,
   input  logic [7:0]                 spp_i,
   input  u2_rx_pkg::stamped_sample_t smp_i,
   input  logic                       smp_valid_i,
   output logic                       smp_ready_o,
   output u2_rx_pkg::line36_t         line_o,
   output logic                       line_valid_o,
   input  logic                       line_ready_i
);

   typedef enum logic [1:0] {
      ST_HDR,
      ST_TIME_HI,
      ST_TIME_LO,
      ST_SAMPLES
   } state_t;

   state_t      state;
   logic        load;      // Output register free this cycle
   logic [15:0] seq_q;
   logic [7:0]  spp_q;     // Count for the packet in flight
   logic [7:0]  smp_cnt;
   logic        last_smp;

   assign load     = !line_valid_o || line_ready_i;
   assign last_smp = (smp_cnt == spp_q - 8'd1);

   // First sample stays at the FIFO head through the time words
   assign smp_ready_o = (state == ST_SAMPLES) && load;

   ////////////////////////////////////////////////////////////////////////////
   // Packet FSM with registered output line

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         state        <= ST_HDR;
         seq_q        <= 16'd0;
         spp_q        <= 8'd1;
         smp_cnt      <= 8'd0;
         line_valid_o <= 1'b0;
      end else if (load) begin
         line_valid_o <= 1'b0;
         case (state)
            ST_HDR: begin
               if (smp_valid_i) begin
                  spp_q        <= spp_i;
                  smp_cnt      <= 8'd0;
                  line_valid_o <= 1'b1;
                  state        <= ST_TIME_HI;
               end
            end
            ST_TIME_HI: begin
               line_valid_o <= 1'b1;
               state        <= ST_TIME_LO;
            end
            ST_TIME_LO: begin
               line_valid_o <= 1'b1;
               state        <= ST_SAMPLES;
            end
            ST_SAMPLES: begin
               if (smp_valid_i) begin
                  line_valid_o <= 1'b1;
                  smp_cnt      <= smp_cnt + 8'd1;
                  if (last_smp) begin
                     seq_q <= seq_q + 16'd1;
                     state <= ST_HDR;
                  end
               end
            end
            default: state <= ST_HDR;
         endcase
      end
   end

   // Line payload
   always_ff @(posedge dsp_clk) begin
      if (load) begin
         case (state)
            ST_HDR:     line_o <= {4'b0001, seq_q, 8'h00, spp_i};   // SOP
            ST_TIME_HI: line_o <= {4'b0000, smp_i.ts[63:32]};
            ST_TIME_LO: line_o <= {4'b0000, smp_i.ts[31:0]};
            default:    line_o <= {2'b00, last_smp, 1'b0, smp_i.smp};   // EOP on last
         endcase
      end
   end

endmodule

/* u2_rx_top.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module u2_rx_top (
   input  logic                          dsp_clk,
   input  logic                          por_rst,
   input  logic                          set_stb_i,
   input  u2_rx_pkg::set_addr_t          set_addr_i,
   input  logic [`U2_SET_DATA_WIDTH-1:0] set_data_i,
   input  logic [`U2_ADC_WIDTH-1:0]      adc_i_i,
   input  logic [`U2_ADC_WIDTH-1:0]      adc_q_i,
   output logic [35:0]                   rx_data_o,
   output logic                          rx_valid_o,
   input  logic                          rx_ready_i,
   output logic                          overrun_o
);

   import u2_rx_pkg::*;

   logic [15:0]     offset_i, offset_q;
   logic            swap_iq, run, clear;
   logic [7:0]      spp, decim;
   vita_time_t      vita_time;
   stamped_sample_t fe_smp, fifo_smp;
   logic            fe_valid, fe_ready, fifo_valid, fifo_ready;
   line36_t         fr_line, out_line;
   logic            fr_valid, fr_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Control

   rx_settings_regs i_regs (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .offset_i_o(offset_i), .offset_q_o(offset_q), .swap_iq_o(swap_iq),
      .run_o(run), .spp_o(spp), .decim_o(decim), .clear_o(clear));

   vita_time_counter i_time (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .vita_time_o(vita_time));

   ////////////////////////////////////////////////////////////////////////////
   // Sample path, front end -> sample FIFO -> framer -> output FIFO

   rx_frontend i_frontend (
      .dsp_clk, .por_rst, .adc_i_i, .adc_q_i,
      .offset_i_i(offset_i), .offset_q_i(offset_q), .swap_iq_i(swap_iq),
      .run_i(run), .decim_i(decim), .clear_i(clear), .vita_time_i(vita_time),
      .smp_ready_i(fe_ready), .smp_o(fe_smp), .smp_valid_o(fe_valid), .overrun_o);

   stream_fifo #(.payload_t(stamped_sample_t), .AW(`U2_SAMPLE_FIFO_AW)) i_smp_fifo (
      .dsp_clk, .por_rst, .clear_i(clear),
      .in_data_i(fe_smp), .in_valid_i(fe_valid), .in_ready_o(fe_ready),
      .out_data_o(fifo_smp), .out_valid_o(fifo_valid), .out_ready_i(fifo_ready));

   vita_rx_framer i_framer (
      .dsp_clk, .por_rst, .clear_i(clear), .spp_i(spp),
      .smp_i(fifo_smp), .smp_valid_i(fifo_valid), .smp_ready_o(fifo_ready),
      .line_o(fr_line), .line_valid_o(fr_valid), .line_ready_i(fr_ready));

   stream_fifo #(.payload_t(line36_t), .AW(`U2_OUT_FIFO_AW)) i_out_fifo (
      .dsp_clk, .por_rst, .clear_i(clear),
      .in_data_i(fr_line), .in_valid_i(fr_valid), .in_ready_o(fr_ready),
      .out_data_o(out_line), .out_valid_o(rx_valid_o), .out_ready_i(rx_ready_i));

   assign rx_data_o = out_line;   // Flags in 35:32

endmodule

/* u2_rx_properties.sv */
`timescale 1ns/1ps

module u2_rx_properties (
   input logic        dsp_clk,
   input logic        por_rst,
   input logic        clear_i,
   input logic [35:0] rx_data_i,
   input logic        rx_valid_i,
   input logic        rx_ready_i,
   input logic        overrun_i
);

   int assert_fails = 0;   // Failed assertion count

   // A stalled line keeps valid high unless a clear empties the FIFO
   a_valid_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rx_valid_i && !rx_ready_i && !clear_i |=> rx_valid_i)
      else begin
         assert_fails++;
         $error("rx_valid_o fell before the line was taken");
      end

   a_data_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rx_valid_i && !rx_ready_i && !clear_i |=> $stable(rx_data_i))
      else begin
         assert_fails++;
         $error("rx_data_o changed while stalled");
      end

   a_overrun_sticky: assert property (@(posedge dsp_clk) disable iff (por_rst)
      overrun_i && !clear_i |=> overrun_i)
      else begin
         assert_fails++;
         $error("overrun_o fell without a clear");
      end

   // A clear empties the output FIFO and drops the overrun
   a_clear_empties: assert property (@(posedge dsp_clk) disable iff (por_rst)
      clear_i |=> !rx_valid_i && !overrun_i)
      else begin
         assert_fails++;
         $error("rx_valid_o or overrun_o still set after a clear");
      end

endmodule

/* u2_rx_checker.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module u2_rx_checker (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic [13:0] adc_i_i,
   input  logic [13:0] adc_q_i,
   input  logic [35:0] rx_data_i,
   input  logic        rx_valid_i,
   input  logic        rx_ready_i,
   input  logic        overrun_i,
   output int          error_count_o,
   output int          pkt_count_o
);

   import u2_rx_pkg::*;

   // Capture record holds swap, offset I, offset Q, ADC I and ADC Q
   logic [60:0] hist [logic [63:0]];
   vita_time_t  mtime;              // Mirror of the DUT time counter
   logic [31:0] time_hi;
   logic        swap_q, run_seen, prev_ok;
   logic [15:0] ofs_i_q, ofs_q_q, exp_seq;
   logic [7:0]  spp_q, decim_q, pkt_spp;
   logic [31:0] ts_hi;
   vita_time_t  pkt_ts, prev_ts;
   logic        first_due;          // Next packet holds the first capture
   vita_time_t  first_ts;
   int          idx;

   function automatic logic [31:0] corrected_sample(logic [60:0] rec);
      logic [13:0] ci;
      logic [13:0] cq;
      logic [15:0] ei;
      logic [15:0] eq;
      ci = rec[60] ? rec[13:0] : rec[27:14];
      cq = rec[60] ? rec[27:14] : rec[13:0];
      ei = {{2{ci[13]}}, ci} - rec[59:44];
      eq = {{2{cq[13]}}, cq} - rec[43:28];
      return {ei, eq};
   endfunction

   task automatic check_value(string name, logic [63:0] exp_v, logic [63:0] act_v);
      if (exp_v !== act_v) begin
         $display("ERROR %s expected %h actual %h", name, exp_v, act_v);
         error_count_o++;
      end
   endtask

   task automatic check_line(logic [35:0] line);
      vita_time_t t;
      int         k;
      case (idx)
         0: begin
            check_value("header_flags", 64'h1, 64'(line[35:32]));
            check_value("header_seq", 64'(exp_seq), 64'(line[31:16]));
            check_value("header_count", 64'(spp_q), 64'(line[15:0]));
            pkt_spp = spp_q;
         end
         1: begin
            check_value("time_hi_flags", 64'h0, 64'(line[35:32]));
            ts_hi = line[31:0];
         end
         2: begin
            check_value("time_lo_flags", 64'h0, 64'(line[35:32]));
            pkt_ts = {ts_hi, line[31:0]};
            if (first_due) begin
               check_value("first_time", first_ts, pkt_ts);
               first_due = 1'b0;
            end
            // Back to back packets are spp * (decim + 1) ticks apart
            if (prev_ok)
               check_value("packet_spacing",
                  prev_ts + 64'(pkt_spp) * (64'(decim_q) + 64'd1), pkt_ts);
         end
         default: begin
            k = idx - 3;
            t = pkt_ts + 64'(k) * (64'(decim_q) + 64'd1);
            check_value("sample_flags", (k == int'(pkt_spp) - 1) ? 64'h2 : 64'h0,
               64'(line[35:32]));
            if (hist.exists(t))
               check_value("sample_value", 64'(corrected_sample(hist[t])),
                  64'(line[31:0]));
            else begin
               $display("Sample %0d has no recorded capture at time %h", k, t);
               error_count_o++;
            end
         end
      endcase
      idx++;
      if (idx == int'(pkt_spp) + 3) begin
         idx = 0;
         exp_seq++;
         pkt_count_o++;
         prev_ts = pkt_ts;
         prev_ok = 1'b1;
      end
   endtask

   initial begin
      error_count_o = 0;
      pkt_count_o   = 0;
   end

   always @(posedge dsp_clk) begin
      if (por_rst) begin
         mtime     = '0;
         time_hi   = '0;
         swap_q    = 1'b0;
         ofs_i_q   = '0;
         ofs_q_q   = '0;
         spp_q     = 8'd1;
         decim_q   = 8'd0;
         run_seen  = 1'b0;
         prev_ok   = 1'b0;
         exp_seq   = '0;
         first_due = 1'b0;
         first_ts  = '0;
         idx       = 0;
      end else begin
         hist[mtime] = {swap_q, ofs_i_q, ofs_q_q, adc_i_i, adc_q_i};
         if (!run_seen && (rx_valid_i || overrun_i)) begin
            $display("Output became active before run was ever written");
            error_count_o++;
         end
         if (rx_valid_i && rx_ready_i)
            check_line(rx_data_i);

         ////////////////////////////////////////////////////////////////////////////
         // New settings act from the next cycle
         mtime = mtime + 64'd1;
         if (set_stb_i) begin
            case (set_addr_i)
               8'(`U2_SR_TIME64 + 0):  time_hi = set_data_i;
               8'(`U2_SR_TIME64 + 1): begin
                  mtime   = {time_hi, set_data_i};
                  prev_ok = 1'b0;
               end
               8'(`U2_SR_RX_FRONT + 0): ofs_i_q = set_data_i[15:0];
               8'(`U2_SR_RX_FRONT + 1): ofs_q_q = set_data_i[15:0];
               8'(`U2_SR_RX_FRONT + 2): swap_q  = set_data_i[0];
               8'(`U2_SR_RX_CTRL + 0): begin
                  run_seen = 1'b1;
                  prev_ok  = 1'b0;   // Restart breaks the spacing
                  if (set_data_i[0]) begin
                     first_due = 1'b1;   // First capture on the next edge
                     first_ts  = mtime;
                  end
               end
               8'(`U2_SR_RX_CTRL + 1):
                  spp_q = (set_data_i[7:0] == 8'd0) ? 8'd1 : set_data_i[7:0];
               8'(`U2_SR_RX_CTRL + 2): decim_q = set_data_i[7:0];
               8'(`U2_SR_RX_CTRL + 3): begin
                  idx       = 0;        // Partial packet is dropped
                  exp_seq   = '0;
                  prev_ok   = 1'b0;
                  first_due = 1'b0;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* tb_u2_rx.sv */
`timescale 1ns/1ps
`include "u2_rx_settings.svh"

module tb_u2_rx;

   import u2_rx_pkg::*;

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic [13:0] adc_i, adc_q;
   logic [35:0] rx_data;
   logic        rx_valid, rx_ready, overrun;
   int          seed = 24951;
   int          ready_mode;   // 0 always ready, 1 random, 2 held low
   int          tb_errors;
   int          chk_errors, pkt_count;
   int          r;

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   u2_rx_top i_dut (
      .dsp_clk, .por_rst, .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .adc_i_i(adc_i), .adc_q_i(adc_q),
      .rx_data_o(rx_data), .rx_valid_o(rx_valid), .rx_ready_i(rx_ready),
      .overrun_o(overrun));

   u2_rx_checker i_checker (
      .dsp_clk, .por_rst, .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .adc_i_i(adc_i), .adc_q_i(adc_q),
      .rx_data_i(rx_data), .rx_valid_i(rx_valid), .rx_ready_i(rx_ready),
      .overrun_i(overrun), .error_count_o(chk_errors), .pkt_count_o(pkt_count));

   bind u2_rx_top u2_rx_properties i_props (
      .dsp_clk, .por_rst, .clear_i(clear), .rx_data_i(rx_data_o),
      .rx_valid_i(rx_valid_o), .rx_ready_i(rx_ready_i), .overrun_i(overrun_o));

   // Random ADC data and back-pressure change on the falling edge
   always @(negedge dsp_clk) begin
      r     = $random(seed);
      adc_i = r[13:0];
      adc_q = r[29:16];
      case (ready_mode)
         0:       rx_ready = 1'b1;
         1:       rx_ready = r[31];
         default: rx_ready = 1'b0;
      endcase
   end

   task automatic write_setting(int addr, logic [31:0] data);
      @(negedge dsp_clk);
      set_stb  = 1'b1;
      set_addr = 8'(addr);
      set_data = data;
      @(negedge dsp_clk);
      set_stb  = 1'b0;
   endtask

   task automatic wait_packets(int n, int limit);
      int target;
      int cycles;
      target = pkt_count + n;
      cycles = 0;
      while (pkt_count < target && cycles < limit) begin
         @(negedge dsp_clk);
         cycles++;
      end
      if (pkt_count < target) begin
         $display("Timed out waiting for %0d packets", n);
         tb_errors++;
      end
   endtask

   task automatic wait_overrun(int limit);
      int cycles;
      cycles = 0;
      while (!overrun && cycles < limit) begin
         @(negedge dsp_clk);
         cycles++;
      end
      if (!overrun) begin
         $display("Timed out waiting for overrun_o to set");
         tb_errors++;
      end
   endtask

   // Output counts as drained once valid stays low for a quiet window
   task automatic wait_output_idle(int quiet, int limit);
      int cycles;
      int idle;
      cycles = 0;
      idle   = 0;
      while (idle < quiet && cycles < limit) begin
         @(negedge dsp_clk);
         cycles++;
         if (rx_valid)
            idle = 0;
         else
            idle++;
      end
      if (idle < quiet) begin
         $display("Timed out waiting for the output to drain");
         tb_errors++;
      end
   endtask

   // Stop, drain whole packets, then clear with the output stalled
   task automatic stop_and_clear();
      write_setting(`U2_SR_RX_CTRL + 0, 32'd0);
      ready_mode = 0;
      wait_output_idle(16, 500);
      ready_mode = 2;
      repeat (2) @(negedge dsp_clk);
      write_setting(`U2_SR_RX_CTRL + 3, 32'd0);
      repeat (3) @(negedge dsp_clk);
      ready_mode = 0;
   endtask

   task automatic configure(logic swap, int spp, int decim);
      int v;
      @(posedge dsp_clk);
      v = $random(seed);
      write_setting(`U2_SR_RX_FRONT + 0, {16'd0, v[15:0]});
      write_setting(`U2_SR_RX_FRONT + 1, {16'd0, v[31:16]});
      write_setting(`U2_SR_RX_FRONT + 2, {31'd0, swap});
      write_setting(`U2_SR_RX_CTRL + 1, 32'(spp));
      write_setting(`U2_SR_RX_CTRL + 2, 32'(decim));
   endtask

   initial begin
      por_rst    = 1'b1;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      adc_i      = '0;
      adc_q      = '0;
      rx_ready   = 1'b0;
      ready_mode = 0;
      tb_errors  = 0;
      repeat (2) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
      repeat (20) @(negedge dsp_clk);   // Outputs must stay low while idle

      // Time load, offsets, no swap
      write_setting(`U2_SR_TIME64 + 0, 32'h0000_0001);
      write_setting(`U2_SR_TIME64 + 1, 32'hffff_ff00);
      configure(1'b0, 4, 2);
      write_setting(`U2_SR_RX_CTRL + 0, 32'd1);
      wait_packets(4, 2000);
      stop_and_clear();

      // Swap on, random back-pressure
      configure(1'b1, 4, 7);
      write_setting(`U2_SR_TIME64 + 1, 32'h0001_2345);
      ready_mode = 1;
      write_setting(`U2_SR_RX_CTRL + 0, 32'd1);
      wait_packets(6, 4000);
      stop_and_clear();

      // Overrun with the output stalled
      configure(1'b0, 4, 0);
      ready_mode = 2;
      write_setting(`U2_SR_RX_CTRL + 0, 32'd1);
      wait_overrun(500);
      stop_and_clear();
      if (overrun) begin
         $display("overrun_o still set after run 0 and clear");
         tb_errors++;
      end
      configure(1'b0, 2, 3);
      write_setting(`U2_SR_RX_CTRL + 0, 32'd1);
      wait_packets(3, 2000);

      $display("Closing: checker errors %0d, testbench errors %0d, assertion failures %0d",
         chk_errors, tb_errors, i_dut.i_props.assert_fails);
      if (chk_errors == 0 && tb_errors == 0 && i_dut.i_props.assert_fails == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* list.f */
+incdir+.
u2_rx_pkg.sv
rx_settings_regs.sv
vita_time_counter.sv
rx_frontend.sv
stream_fifo.sv
vita_rx_framer.sv
u2_rx_top.sv
u2_rx_properties.sv
u2_rx_checker.sv
tb_u2_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RX data path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f list.f \
   --top-module tb_u2_rx \
   -o sim_u2_rx

./obj_dir/sim_u2_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   exit 0
fi
exit 1
